/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_predictor
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended without a result"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+verilog
verilog/bp_pkg.sv
verilog/bp_history_table.sv
verilog/bp_counter_table.sv
verilog/bp_target_buffer.sv
verilog/bp_train_stage.sv
verilog/fetch_pc.sv
verilog/fetch_predictor.sv
testbench/tb_clock.sv
testbench/fetch_predictor_sva.sv
testbench/tb_fetch_predictor.sv

/* testbench/fetch_predictor_sva.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module fetch_predictor_sva
    import bp_pkg::*;
(
    input logic           clk_i,
    input logic           rst_i,
    input logic           fetch_ready_i,
    input logic           redirect_i,
    input logic [31:0]    redirect_pc_i,
    input logic [31:0]    pc_i,
    input bp_prediction_t prediction_i
);

    // Failed properties so far, read by the testbench top
    int unsigned fail_count = 0;

    reset_state: assert property (@(posedge clk_i) disable iff (!rst_i)
        $rose(rst_i) |-> (pc_i == `BP_PC_INIT) && !prediction_i.taken)
        else begin
            $error("fetch PC or prediction wrong right after reset");
            fail_count++;
        end

    // Not-taken fetch steps one word
    sequential_fetch: assert property (@(posedge clk_i) disable iff (!rst_i)
        !redirect_i && fetch_ready_i && !prediction_i.taken |=> pc_i == $past(pc_i) + 32'd4)
        else begin
            $error("fetch PC did not advance by one word");
            fail_count++;
        end

    hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
        !redirect_i && !fetch_ready_i |=> pc_i == $past(pc_i))
        else begin
            $error("fetch PC moved while the cache was not ready");
            fail_count++;
        end

    redirect_load: assert property (@(posedge clk_i) disable iff (!rst_i)
        redirect_i |=> pc_i == $past(redirect_pc_i))
        else begin
            $error("redirect address not loaded into the fetch PC");
            fail_count++;
        end

    taken_follow: assert property (@(posedge clk_i) disable iff (!rst_i)
        !redirect_i && fetch_ready_i && prediction_i.taken
        |=> pc_i == {$past(prediction_i.target), 1'b0})
        else begin
            $error("fetch PC did not follow a taken prediction");
            fail_count++;
        end

endmodule

bind fetch_predictor fetch_predictor_sva fetch_predictor_sva_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .fetch_ready_i(fetch_ready_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .pc_i         (pc_o),
    .prediction_i (prediction_o)
);

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset low across the first two rising edges, released on a falling edge
    initial begin
        rst_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b1;
    end

endmodule

/* testbench/tb_fetch_predictor.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module tb_fetch_predictor
    import bp_pkg::*;
();

    localparam int          CYCLE_LIMIT   = 2000;
    localparam logic [31:0] BRANCH_PC     = 32'h0010_0240;
    localparam logic [31:0] ALIAS_PC      = BRANCH_PC + 32'd1024;
    localparam logic [31:0] BRANCH_TARGET = 32'h0010_1000;

    logic           clk;
    logic           rst;
    logic           fetch_ready;
    logic           redirect;
    logic [31:0]    redirect_pc;
    bp_resolve_t    resolve;
    logic [31:0]    pc;
    bp_prediction_t prediction;

    integer         seed = 80340;
    logic [31:0]    rnd;
    int             cycle_count = 0;
    logic           run_checks = 1'b0;

    // Reference model of the tables and the fetch PC
    logic [`BP_HIST_BITS-1:0] hist_m [`BP_BHT_DEPTH];
    logic [1:0]               cnt_m [`BP_CNT_DEPTH];
    logic                     bvalid_m [`BP_BTB_DEPTH];
    logic [31:2]              btag_m [`BP_BTB_DEPTH];
    logic [31:1]              btarget_m [`BP_BTB_DEPTH];
    logic [31:0]              pc_m;
    bp_resolve_t              staged;
    logic                     staged_valid;
    bp_prediction_t           model_next;
    bp_prediction_t           model_pred;

    tb_clock tb_clock_i (
        .clk_o(clk),
        .rst_o(rst)
    );

    fetch_predictor fetch_predictor_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .fetch_ready_i(fetch_ready),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .resolve_i    (resolve),
        .pc_o         (pc),
        .prediction_o (prediction)
    );

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        stop_run();
    endtask

    function automatic bp_prediction_t predict_model(input logic [31:0] addr);
        bp_prediction_t             p;
        logic [`BP_HIST_BITS-1:0]   h;
        logic [`BP_BTB_IDX_BITS-1:0] bi;
        logic                       hit;
        h        = hist_m[addr[`BP_BHT_IDX_BITS+1:2]];
        bi       = addr[`BP_BTB_IDX_BITS+1:2];
        hit      = bvalid_m[bi] && (btag_m[bi] == addr[31:2]);
        p.taken  = hit && (cnt_m[h] >= BP_WEAK_TAKEN);
        p.target = p.taken ? btarget_m[bi] : addr[31:1] + 31'd2;
        return p;
    endfunction

    function automatic void train_model(input bp_resolve_t r);
        logic [`BP_BHT_IDX_BITS-1:0] hi;
        logic [`BP_BTB_IDX_BITS-1:0] bi;
        logic [`BP_HIST_BITS-1:0]    old;
        hi  = r.pc[`BP_BHT_IDX_BITS+1:2];
        bi  = r.pc[`BP_BTB_IDX_BITS+1:2];
        old = hist_m[hi];
        hist_m[hi] = {old[`BP_HIST_BITS-2:0], r.taken};
        if (r.taken && cnt_m[old] != BP_STRONG_TAKEN) begin
            cnt_m[old] = cnt_m[old] + 2'd1;
        end else if (!r.taken && cnt_m[old] != BP_STRONG_NOT_TAKEN) begin
            cnt_m[old] = cnt_m[old] - 2'd1;
        end
        bvalid_m[bi]  = 1'b1;
        btag_m[bi]    = r.pc[31:2];
        btarget_m[bi] = r.target;
    endfunction

    // Next PC comes from the tables as they were before this edge's write
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `BP_BHT_DEPTH; i++) begin
                hist_m[i] = '0;
            end
            for (int i = 0; i < `BP_CNT_DEPTH; i++) begin
                cnt_m[i] = BP_STRONG_NOT_TAKEN;
            end
            for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
                bvalid_m[i] = 1'b0;
            end
            pc_m         = `BP_PC_INIT;
            staged       = '0;
            staged_valid = 1'b0;
        end else begin
            model_next = predict_model(pc_m);
            if (redirect) begin
                pc_m = redirect_pc;
            end else if (fetch_ready) begin
                pc_m = {model_next.target, 1'b0};
            end
            if (staged_valid) begin
                train_model(staged);
            end
            staged_valid = resolve.valid && resolve.trainable;
            staged       = resolve;
        end
    end

    always @(negedge clk) begin
        if (run_checks) begin
            model_pred = predict_model(pc_m);
            assert (pc == pc_m)
                else value_error($sformatf("pc_o %h, expected %h", pc, pc_m));
            assert (prediction == model_pred)
                else value_error($sformatf("prediction %h at pc %h, expected %h",
                                           prediction, pc, model_pred));
            assert (fetch_predictor_i.fetch_predictor_sva_i.fail_count == 0) else begin
                $display("a concurrent assertion on the DUT failed");
                stop_run();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    task automatic redirect_to(input logic [31:0] addr, input logic ready);
        redirect    = 1'b1;
        redirect_pc = addr;
        fetch_ready = ready;
        @(negedge clk);
        redirect    = 1'b0;
        fetch_ready = 1'b0;
    endtask

    task automatic resolve_branch(input logic taken, input logic trainable);
        resolve.valid     = 1'b1;
        resolve.trainable = trainable;
        resolve.pc        = BRANCH_PC;
        resolve.taken     = taken;
        resolve.target    = BRANCH_TARGET[31:1];
        @(negedge clk);
        resolve = '0;
    endtask

    task automatic expect_taken(input logic exp, input string what);
        assert (prediction.taken == exp)
            else value_error($sformatf("%s, taken %b at pc %h", what, prediction.taken, pc));
    endtask

    initial begin
        fetch_ready = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        resolve     = '0;
        @(posedge rst);
        @(negedge clk);
        run_checks = 1'b1;

        // Untrained fetch under random back-pressure
        repeat (40) begin
            rnd = $random(seed);
            fetch_ready = rnd[0];
            @(negedge clk);
        end
        repeat (6) begin
            rnd = $random(seed);
            redirect_to({12'h001, rnd[19:2], 2'b00}, rnd[20]);
        end

        redirect_to(BRANCH_PC, 1'b0);
        repeat (12) resolve_branch(1'b1, 1'b0);
        repeat (2) @(negedge clk);
        expect_taken(1'b0, "untrainable resolves changed the prediction");

        repeat (12) resolve_branch(1'b1, 1'b1);
        repeat (2) @(negedge clk);
        expect_taken(1'b1, "trained branch not predicted taken");
        assert (prediction.target == BRANCH_TARGET[31:1])
            else value_error($sformatf("predicted target %h", {prediction.target, 1'b0}));
        fetch_ready = 1'b1;
        @(negedge clk);
        fetch_ready = 1'b0;
        assert (pc == BRANCH_TARGET)
            else value_error($sformatf("pc_o %h after taken fetch", pc));

        // Same indices, different tag
        redirect_to(ALIAS_PC, 1'b0);
        expect_taken(1'b0, "aliased PC hit the target buffer");

        repeat (12) resolve_branch(1'b0, 1'b1);
        repeat (2) @(negedge clk);
        redirect_to(BRANCH_PC, 1'b0);
        expect_taken(1'b0, "branch still taken after not-taken training");

        repeat (30) begin
            rnd = $random(seed);
            if (rnd[3:0] == 4'd0) begin
                redirect_to(BRANCH_PC, rnd[4]);
            end else begin
                fetch_ready = rnd[5];
                @(negedge clk);
            end
        end
        fetch_ready = 1'b0;
        repeat (2) @(negedge clk);

        if (fetch_predictor_i.fetch_predictor_sva_i.fail_count != 0) begin
            stop_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* verilog/bp_counter_table.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module bp_counter_table
    import bp_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [`BP_HIST_BITS-1:0] fetch_history_i,
    input  logic [`BP_HIST_BITS-1:0] train_history_i,
    input  bp_train_t                train_i,
    output logic                     predict_taken_o
);

    bp_state_e cnt_q [`BP_CNT_DEPTH];
    bp_state_e fetch_state;
    bp_state_e train_state;
    bp_state_e train_next;

    // One step toward the outcome, held at either end
    function automatic bp_state_e step_counter(bp_state_e state, logic taken);
        bp_state_e next;
        case (state)
            BP_STRONG_NOT_TAKEN: next = taken ? BP_WEAK_NOT_TAKEN : BP_STRONG_NOT_TAKEN;
            BP_WEAK_NOT_TAKEN:   next = taken ? BP_WEAK_TAKEN     : BP_STRONG_NOT_TAKEN;
            BP_WEAK_TAKEN:       next = taken ? BP_STRONG_TAKEN   : BP_WEAK_NOT_TAKEN;
            BP_STRONG_TAKEN:     next = taken ? BP_STRONG_TAKEN   : BP_WEAK_TAKEN;
            default:             next = BP_STRONG_NOT_TAKEN;
        endcase
        return next;
    endfunction

    assign fetch_state = cnt_q[fetch_history_i];
    assign train_state = cnt_q[train_history_i];
    assign train_next  = step_counter(train_state, train_i.taken);

    // Upper bit of the state is the taken decision
    assign predict_taken_o = fetch_state[1];

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `BP_CNT_DEPTH; i++) begin
                cnt_q[i] <= BP_STRONG_NOT_TAKEN;
            end
        end else if (train_i.valid) begin
            // Indexed by the history before this branch's shift
            cnt_q[train_history_i] <= train_next;
        end
    end

endmodule

/* verilog/bp_history_table.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module bp_history_table
    import bp_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [31:0]              fetch_pc_i,
    input  bp_train_t                train_i,
    output logic [`BP_HIST_BITS-1:0] fetch_history_o,
    output logic [`BP_HIST_BITS-1:0] train_history_o
);

    logic [`BP_HIST_BITS-1:0]   hist_q [`BP_BHT_DEPTH];
    logic [`BP_BHT_IDX_BITS-1:0] fetch_idx;
    logic [`BP_BHT_IDX_BITS-1:0] train_idx;
    logic [`BP_HIST_BITS-1:0]   hist_next;

    // Word-aligned index, low two PC bits skipped
    assign fetch_idx = fetch_pc_i[`BP_BHT_IDX_BITS+1:2];
    assign train_idx = train_i.pc[`BP_BHT_IDX_BITS+1:2];

    assign fetch_history_o = hist_q[fetch_idx];
    assign train_history_o = hist_q[train_idx];

    // Shift in the newest outcome at the LSB
    assign hist_next = {train_history_o[`BP_HIST_BITS-2:0], train_i.taken};

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `BP_BHT_DEPTH; i++) begin
                hist_q[i] <= '0;
            end
        end else if (train_i.valid) begin
            hist_q[train_idx] <= hist_next;
        end
    end

endmodule

/* verilog/bp_pkg.sv */
package bp_pkg;

    // Two-bit saturating counter, MSB set means predict taken
    typedef enum logic [1:0] {
        BP_STRONG_NOT_TAKEN = 2'b00,
        BP_WEAK_NOT_TAKEN   = 2'b01,
        BP_WEAK_TAKEN       = 2'b10,
        BP_STRONG_TAKEN     = 2'b11
    } bp_state_e;

    // Resolved branch coming back from execute
    typedef struct packed {
        logic        valid;
        logic        trainable;
        logic [31:0] pc;
        logic        taken;
        logic [31:1] target;
    } bp_resolve_t;

    // Table write, valid means update this cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:1] target;
    } bp_train_t;

    // Prediction for the current fetch PC
    typedef struct packed {
        logic        taken;
        logic [31:1] target;
    } bp_prediction_t;

    // One target buffer entry
    typedef struct packed {
        logic [31:2] tag;
        logic [31:1] target;
    } bp_btb_entry_t;

endpackage

/* verilog/bp_settings.svh */
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Fetch address after reset
`define BP_PC_INIT 32'h0010_0000

// Branch history length, also the counter table index width
`define BP_HIST_BITS 10

// History table index, taken from PC[9:2]
`define BP_BHT_IDX_BITS 8

// Target buffer index, taken from PC[8:2]
`define BP_BTB_IDX_BITS 7

`define BP_BHT_DEPTH (1 << `BP_BHT_IDX_BITS)
`define BP_CNT_DEPTH (1 << `BP_HIST_BITS)
`define BP_BTB_DEPTH (1 << `BP_BTB_IDX_BITS)

`endif

/* verilog/bp_target_buffer.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module bp_target_buffer
    import bp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [31:0] fetch_pc_i,
    input  bp_train_t   train_i,
    output logic        hit_o,
    output logic [31:1] target_o
);

    bp_btb_entry_t               entry_q [`BP_BTB_DEPTH];
    logic [`BP_BTB_DEPTH-1:0]    valid_q;
    logic [`BP_BTB_IDX_BITS-1:0] fetch_idx;
    logic [`BP_BTB_IDX_BITS-1:0] train_idx;
    bp_btb_entry_t               fetch_entry;
    bp_btb_entry_t               train_entry;

    assign fetch_idx = fetch_pc_i[`BP_BTB_IDX_BITS+1:2];
    assign train_idx = train_i.pc[`BP_BTB_IDX_BITS+1:2];

    assign fetch_entry = entry_q[fetch_idx];

    // Full upper PC stored as tag, so aliases never hit
    assign hit_o    = valid_q[fetch_idx] && (fetch_entry.tag == fetch_pc_i[31:2]);
    assign target_o = fetch_entry.target;

    assign train_entry.tag    = train_i.pc[31:2];
    assign train_entry.target = train_i.target;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            valid_q <= '0;
        end else if (train_i.valid) begin
            valid_q[train_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
                entry_q[i] <= '0;
            end
        end else if (train_i.valid) begin
            // Written on not-taken outcomes too, the counter decides
            entry_q[train_idx] <= train_entry;
        end
    end

endmodule

/* verilog/bp_train_stage.sv */
`timescale 1ns/1ps

module bp_train_stage
    import bp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  bp_resolve_t resolve_i,
    output bp_train_t   train_o
);

    logic        accept;
    logic        valid_q;
    logic [31:0] pc_q;
    logic        taken_q;
    logic [31:1] target_q;

    // Branches with the predictor disabled never touch the tables
    assign accept = resolve_i.valid && resolve_i.trainable;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pc_q     <= resolve_i.pc;
            taken_q  <= resolve_i.taken;
            target_q <= resolve_i.target;
        end
    end

    // Tables read at this PC now and write on the next edge
    assign train_o.valid  = valid_q;
    assign train_o.pc     = pc_q;
    assign train_o.taken  = taken_q;
    assign train_o.target = target_q;

endmodule

/* verilog/fetch_pc.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module fetch_pc
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           fetch_ready_i,
    input  logic           redirect_i,
    input  logic [31:0]    redirect_pc_i,
    input  logic           predict_taken_i,
    input  logic           btb_hit_i,
    input  logic [31:1]    btb_target_i,
    output logic [31:0]    pc_o,
    output bp_prediction_t prediction_o
);

    logic [31:0]    pc_q;
    bp_prediction_t pred;

    // Taken needs both the counter and a matching target
    assign pred.taken  = predict_taken_i && btb_hit_i;
    assign pred.target = pred.taken ? btb_target_i : pc_q[31:1] + 31'd2;

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            pc_q <= `BP_PC_INIT;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_ready_i) begin
            pc_q <= {pred.target, 1'b0};
        end
    end

    assign pc_o         = pc_q;
    assign prediction_o = pred;

endmodule

/* verilog/fetch_predictor.sv */
`timescale 1ns/1ps

`include "bp_settings.svh"

module fetch_predictor
    import bp_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           fetch_ready_i,
    input  logic           redirect_i,
    input  logic [31:0]    redirect_pc_i,
    input  bp_resolve_t    resolve_i,
    output logic [31:0]    pc_o,
    output bp_prediction_t prediction_o
);

    logic [31:0]              pc;
    logic [`BP_HIST_BITS-1:0] fetch_history;
    logic [`BP_HIST_BITS-1:0] train_history;
    logic                     predict_taken;
    logic                     btb_hit;
    logic [31:1]              btb_target;
    bp_train_t                train;

    bp_train_stage bp_train_stage_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .resolve_i(resolve_i),
        .train_o  (train)
    );

    bp_history_table bp_history_table_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_pc_i     (pc),
        .train_i        (train),
        .fetch_history_o(fetch_history),
        .train_history_o(train_history)
    );

    bp_counter_table bp_counter_table_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_history_i(fetch_history),
        .train_history_i(train_history),
        .train_i        (train),
        .predict_taken_o(predict_taken)
    );

    bp_target_buffer bp_target_buffer_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .fetch_pc_i(pc),
        .train_i   (train),
        .hit_o     (btb_hit),
        .target_o  (btb_target)
    );

    fetch_pc fetch_pc_i (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_ready_i  (fetch_ready_i),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .predict_taken_i(predict_taken),
        .btb_hit_i      (btb_hit),
        .btb_target_i   (btb_target),
        .pc_o           (pc),
        .prediction_o   (prediction_o)
    );

    assign pc_o = pc;

endmodule
